// File: design/mem_access_defines.svh
`ifndef MEM_ACCESS_DEFINES_SVH
`define MEM_ACCESS_DEFINES_SVH

// ------------------------------
// data sram geometry
// ------------------------------

// number of 32-bit words in the data sram
`define MEM_SRAM_DEPTH 256

// word index width, log2 of the depth
// byte address bits [MEM_SRAM_AW+1:2] select the word
`define MEM_SRAM_AW 8

`endif

// File: design/mem_access_pkg.sv
package mem_access_pkg;

    // ------------------------------
    // shared vector types
    // ------------------------------

    // data or address word
    typedef logic [31:0] word_t;

    // register file index
    typedef logic [4:0] reg_addr_t;

    // csr address
    typedef logic [11:0] csr_addr_t;

    // burst length, beats = value + 1
    typedef logic [7:0] burst_len_t;

    // 0 byte, 1 halfword, 2 or 3 word
    typedef logic [1:0] access_size_t;

    // error code from execute
    typedef logic [3:0] err_type_t;

    // one enable per byte lane
    typedef logic [3:0] byte_en_t;

    // ------------------------------
    // load/store unit sequencing
    // ------------------------------

    typedef enum logic [1:0] {
        st_idle,
        st_read,
        st_burst,
        st_write
    } lsu_state_t;

endpackage

// File: design/mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter (
    input  logic                          clock,
    input  logic                          reset,

    // fetch side
    input  logic                          cah_valid,
    input  mem_access_pkg::word_t         cah_addr,
    input  logic                          cah_burst,
    input  mem_access_pkg::burst_len_t    cah_rlen,
    output logic                          cah_ready,
    output mem_access_pkg::word_t         cah_data,

    // execute side
    input  logic                          exu_valid,
    output logic                          exu_ready,
    input  logic                          exu_men,
    input  mem_access_pkg::reg_addr_t     exu_ard,
    input  mem_access_pkg::word_t         exu_rd,
    input  logic                          exu_gen,
    input  mem_access_pkg::csr_addr_t     exu_acsr,
    input  mem_access_pkg::word_t         exu_csr,
    input  logic                          exu_sen,
    input  logic                          exu_write,
    input  mem_access_pkg::word_t         exu_wdata,
    input  mem_access_pkg::word_t         exu_addr,
    input  mem_access_pkg::access_size_t  exu_mask,
    input  logic                          exu_rsign,

    // read channel
    output logic                          lsu_rvalid,
    input  logic                          lsu_rready,
    input  mem_access_pkg::word_t         lsu_rdata,
    output mem_access_pkg::word_t         lsu_raddr,
    output mem_access_pkg::burst_len_t    lsu_rlen,
    output logic                          lsu_burst,
    output logic                          lsu_rsign,
    output mem_access_pkg::access_size_t  lsu_rmask,

    // write channel
    output logic                          lsu_wvalid,
    input  logic                          lsu_wready,
    output mem_access_pkg::word_t         lsu_wdata,
    output mem_access_pkg::word_t         lsu_waddr,
    output mem_access_pkg::access_size_t  lsu_wmask,

    // write-back
    output logic                          reg_valid,
    output logic                          csr_valid,
    output mem_access_pkg::word_t         reg_data,
    output mem_access_pkg::word_t         csr_data,
    output mem_access_pkg::reg_addr_t     reg_addr,
    output mem_access_pkg::csr_addr_t     csr_addr,

    // side channels
    input  logic                          erri,
    input  mem_access_pkg::err_type_t     errtpi,
    output logic                          erro,
    output mem_access_pkg::err_type_t     errtpo,
    input  logic                          in_fencei,
    output logic                          ot_fencei
);
    import mem_access_pkg::*;

    // ------------------------------
    // state and latches
    // ------------------------------

    logic         busy;
    logic         fetch_own;
    logic         handsk;
    logic         mem_hs;
    logic         wr_done;
    logic         rd_done;

    // latched store
    logic         wvalid_q;
    word_t        waddr_q;
    word_t        wdata_q;
    access_size_t wmask_q;

    // latched load
    logic         rvalid_q;
    word_t        raddr_q;
    access_size_t rmask_q;
    logic         rsign_q;
    reg_addr_t    wb_addr_q;

    // fetch gets the read channel only when no load or store is in flight
    assign fetch_own = ~busy & cah_valid;

    assign handsk  = exu_valid & exu_ready;
    assign mem_hs  = handsk & exu_men;
    assign wr_done = lsu_wvalid & lsu_wready;
    assign rd_done = rvalid_q & lsu_rvalid & lsu_rready;

    // ------------------------------
    // execute handshake
    // ------------------------------

    // non-memory requests may slip past a pending fetch
    assign exu_ready = ~busy & (~cah_valid | (~exu_men & ~erri));

    assign erro      = handsk & erri;
    assign errtpo    = errtpi;
    assign ot_fencei = handsk & in_fencei;

    // ------------------------------
    // load/store unit channels
    // ------------------------------

    assign lsu_rvalid = fetch_own ? 1'b1      : rvalid_q;
    assign lsu_raddr  = fetch_own ? cah_addr  : raddr_q;
    assign lsu_rlen   = fetch_own ? cah_rlen  : '0;
    assign lsu_burst  = fetch_own ? cah_burst : 1'b0;
    assign lsu_rmask  = fetch_own ? 2'b11     : rmask_q;
    assign lsu_rsign  = fetch_own ? 1'b0      : rsign_q;

    assign lsu_wvalid = fetch_own ? 1'b0 : wvalid_q;
    assign lsu_waddr  = waddr_q;
    assign lsu_wdata  = wdata_q;
    assign lsu_wmask  = wmask_q;

    // fetch beats straight back to the requester
    assign cah_ready = fetch_own & lsu_rready;
    assign cah_data  = fetch_own ? lsu_rdata : '0;

    // ------------------------------
    // write-back steering
    // ------------------------------

    assign reg_valid = (handsk & ~exu_men & exu_gen) | rd_done;
    assign reg_data  = rvalid_q ? lsu_rdata : exu_rd;
    assign reg_addr  = rvalid_q ? wb_addr_q : exu_ard;

    assign csr_valid = handsk & exu_sen;
    assign csr_data  = exu_csr;
    assign csr_addr  = exu_acsr;

    // busy from memory handshake until load write-back or store commit
    always_ff @(posedge clock) begin
        if (reset) begin
            busy     <= 1'b0;
            wvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            if (mem_hs) begin
                busy <= 1'b1;
            end else if (rd_done | wr_done) begin
                busy <= 1'b0;
            end

            if (mem_hs & exu_write) begin
                wvalid_q <= 1'b1;
            end else if (wr_done) begin
                wvalid_q <= 1'b0;
            end

            if (mem_hs & ~exu_write) begin
                rvalid_q <= 1'b1;
            end else if (rd_done) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // request fields, held until completion
    always_ff @(posedge clock) begin
        if (mem_hs & exu_write) begin
            waddr_q <= exu_addr;
            wdata_q <= exu_wdata;
            wmask_q <= exu_mask;
        end
        if (mem_hs & ~exu_write) begin
            raddr_q   <= exu_addr;
            rmask_q   <= exu_mask;
            rsign_q   <= exu_rsign;
            wb_addr_q <= exu_ard;
        end
    end

endmodule

// File: design/load_store_unit.sv
`timescale 1ns/10ps
`include "mem_access_defines.svh"

module load_store_unit (
    input  logic                          clock,
    input  logic                          reset,

    // read channel
    input  logic                          lsu_rvalid,
    output logic                          lsu_rready,
    output mem_access_pkg::word_t         lsu_rdata,
    input  mem_access_pkg::word_t         lsu_raddr,
    input  mem_access_pkg::burst_len_t    lsu_rlen,
    input  logic                          lsu_burst,
    input  logic                          lsu_rsign,
    input  mem_access_pkg::access_size_t  lsu_rmask,

    // write channel
    input  logic                          lsu_wvalid,
    output logic                          lsu_wready,
    input  mem_access_pkg::word_t         lsu_wdata,
    input  mem_access_pkg::word_t         lsu_waddr,
    input  mem_access_pkg::access_size_t  lsu_wmask,

    // sram port
    output logic                          sram_en,
    output mem_access_pkg::byte_en_t      sram_we,
    output logic [`MEM_SRAM_AW-1:0]       sram_index,
    output mem_access_pkg::word_t         sram_wdata,
    input  mem_access_pkg::word_t         sram_rdata
);
    import mem_access_pkg::*;

    lsu_state_t              state;
    logic                    issuing;
    logic                    data_vld;
    burst_len_t              issue_left;
    burst_len_t              beats_left;
    logic [`MEM_SRAM_AW-1:0] index_q;

    // load format
    logic [1:0]              lane_q;
    access_size_t            size_q;
    logic                    sign_q;

    // store payload
    word_t                   wr_data_q;
    byte_en_t                wr_be_q;
    word_t                   lane_data;
    byte_en_t                lane_be;
    word_t                   shifted;

    // ------------------------------
    // lane placement
    // ------------------------------

    always_comb begin
        case (lsu_wmask)
            2'd0: begin
                lane_data = lsu_wdata << {lsu_waddr[1:0], 3'b000};
                lane_be   = 4'b0001 << lsu_waddr[1:0];
            end
            2'd1: begin
                lane_data = lsu_wdata << {lsu_waddr[1], 4'b0000};
                lane_be   = lsu_waddr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                lane_data = lsu_wdata;
                lane_be   = 4'b1111;
            end
        endcase
    end

    // addressed lane down to bit 0, then extend
    always_comb begin
        shifted = sram_rdata >> {lane_q, 3'b000};
        case (size_q)
            2'd0:    lsu_rdata = {{24{sign_q & shifted[7]}}, shifted[7:0]};
            2'd1:    lsu_rdata = {{16{sign_q & shifted[15]}}, shifted[15:0]};
            default: lsu_rdata = sram_rdata;
        endcase
    end

    // ------------------------------
    // sram drive
    // ------------------------------

    assign sram_en    = issuing | (state == st_write);
    assign sram_we    = (state == st_write) ? wr_be_q : '0;
    assign sram_index = index_q;
    assign sram_wdata = wr_data_q;

    // read data lands one cycle after the enable
    assign lsu_rready = data_vld;
    assign lsu_wready = (state == st_write);

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= st_idle;
            issuing    <= 1'b0;
            data_vld   <= 1'b0;
            issue_left <= '0;
            beats_left <= '0;
        end else begin
            data_vld <= issuing;
            if (issuing) begin
                if (issue_left == '0) begin
                    issuing <= 1'b0;
                end else begin
                    issue_left <= issue_left - 1'b1;
                end
            end
            case (state)
                st_idle: begin
                    if (lsu_rvalid) begin
                        issuing    <= 1'b1;
                        issue_left <= lsu_burst ? lsu_rlen : '0;
                        beats_left <= lsu_burst ? lsu_rlen : '0;
                        state      <= lsu_burst ? st_burst : st_read;
                    end else if (lsu_wvalid) begin
                        state <= st_write;
                    end
                end
                st_read: begin
                    if (data_vld) begin
                        state <= st_idle;
                    end
                end
                st_burst: begin
                    if (data_vld) begin
                        if (beats_left == '0) begin
                            state <= st_idle;
                        end else begin
                            beats_left <= beats_left - 1'b1;
                        end
                    end
                end
                default: begin
                    // write commits in its single cycle
                    state <= st_idle;
                end
            endcase
        end
    end

    // word index and access format, stepped once per issued beat
    always_ff @(posedge clock) begin
        if (state == st_idle) begin
            if (lsu_rvalid) begin
                index_q <= lsu_raddr[`MEM_SRAM_AW+1:2];
                lane_q  <= lsu_raddr[1:0];
                size_q  <= lsu_rmask;
                sign_q  <= lsu_rsign;
            end else if (lsu_wvalid) begin
                index_q   <= lsu_waddr[`MEM_SRAM_AW+1:2];
                wr_data_q <= lane_data;
                wr_be_q   <= lane_be;
            end
        end else if (issuing) begin
            index_q <= index_q + 1'b1;
        end
    end

endmodule

// File: design/data_sram.sv
`timescale 1ns/10ps
`include "mem_access_defines.svh"

module data_sram (
    input  logic                          clock,
    input  logic                          sram_en,
    input  mem_access_pkg::byte_en_t      sram_we,
    input  logic [`MEM_SRAM_AW-1:0]       sram_index,
    input  mem_access_pkg::word_t         sram_wdata,
    output mem_access_pkg::word_t         sram_rdata
);
    import mem_access_pkg::*;

    localparam int num_lanes = $bits(byte_en_t);

    // ------------------------------
    // storage
    // ------------------------------

    word_t mem [0:`MEM_SRAM_DEPTH-1];

    // byte-masked write
    always_ff @(posedge clock) begin
        if (sram_en) begin
            for (int b = 0; b < num_lanes; b++) begin
                if (sram_we[b]) begin
                    mem[sram_index][b*8 +: 8] <= sram_wdata[b*8 +: 8];
                end
            end
        end
    end

    // registered read, only when no lane is written
    always_ff @(posedge clock) begin
        if (sram_en && sram_we == '0) begin
            sram_rdata <= mem[sram_index];
        end
    end

endmodule

// File: design/mem_access_top.sv
`timescale 1ns/10ps
`include "mem_access_defines.svh"

module mem_access_top (
    input  logic                          clock,
    input  logic                          reset,

    // fetch port
    input  logic                          cah_valid,
    input  mem_access_pkg::word_t         cah_addr,
    input  logic                          cah_burst,
    input  mem_access_pkg::burst_len_t    cah_rlen,
    output logic                          cah_ready,
    output mem_access_pkg::word_t         cah_data,

    // execute port
    input  logic                          exu_valid,
    output logic                          exu_ready,
    input  logic                          exu_men,
    input  mem_access_pkg::reg_addr_t     exu_ard,
    input  mem_access_pkg::word_t         exu_rd,
    input  logic                          exu_gen,
    input  mem_access_pkg::csr_addr_t     exu_acsr,
    input  mem_access_pkg::word_t         exu_csr,
    input  logic                          exu_sen,
    input  logic                          exu_write,
    input  mem_access_pkg::word_t         exu_wdata,
    input  mem_access_pkg::word_t         exu_addr,
    input  mem_access_pkg::access_size_t  exu_mask,
    input  logic                          exu_rsign,

    // write-back
    output logic                          reg_valid,
    output logic                          csr_valid,
    output mem_access_pkg::word_t         reg_data,
    output mem_access_pkg::word_t         csr_data,
    output mem_access_pkg::reg_addr_t     reg_addr,
    output mem_access_pkg::csr_addr_t     csr_addr,

    // side channels
    input  logic                          erri,
    input  mem_access_pkg::err_type_t     errtpi,
    output logic                          erro,
    output mem_access_pkg::err_type_t     errtpo,
    input  logic                          in_fencei,
    output logic                          ot_fencei
);
    import mem_access_pkg::*;

    // ------------------------------
    // arbiter to load/store unit
    // ------------------------------

    logic         lsu_rvalid;
    logic         lsu_rready;
    word_t        lsu_rdata;
    word_t        lsu_raddr;
    burst_len_t   lsu_rlen;
    logic         lsu_burst;
    logic         lsu_rsign;
    access_size_t lsu_rmask;

    logic         lsu_wvalid;
    logic         lsu_wready;
    word_t        lsu_wdata;
    word_t        lsu_waddr;
    access_size_t lsu_wmask;

    // load/store unit to sram
    logic                    sram_en;
    byte_en_t                sram_we;
    logic [`MEM_SRAM_AW-1:0] sram_index;
    word_t                   sram_wdata;
    word_t                   sram_rdata;

    // port names match across the hierarchy
    mem_arbiter arbiter_i (.*);

    load_store_unit lsu_i (.*);

    data_sram sram_i (.*);

endmodule

// File: testbench/mem_arbiter_checker.sv
`timescale 1ns/10ps

module mem_arbiter_checker (
    input logic clock,
    input logic reset,
    input logic wvalid_q,
    input logic exu_ready,
    input logic lsu_rvalid,
    input logic lsu_rready,
    input logic lsu_wvalid,
    input logic rvalid_q,
    input logic reg_valid
);

    // ------------------------------
    // handshake rules
    // ------------------------------

    // no new request while a load or store is in flight
    ready_low_when_busy: assert property (
        @(posedge clock) disable iff (reset) (rvalid_q || wvalid_q) |-> !exu_ready
    ) else $error("exu_ready high while a load or store is in flight");

    // read request held until the unit answers
    rvalid_held: assert property (
        @(posedge clock) disable iff (reset) (lsu_rvalid && !lsu_rready) |=> lsu_rvalid
    ) else $error("lsu_rvalid dropped before lsu_rready");

    no_store_with_load: assert property (
        @(posedge clock) disable iff (reset) !(lsu_wvalid && rvalid_q)
    ) else $error("store and load pending together");

    // load write-back only on the read beat
    load_wb_on_beat: assert property (
        @(posedge clock) disable iff (reset) (reg_valid && rvalid_q) |-> (lsu_rvalid && lsu_rready)
    ) else $error("load write-back outside the read handshake");

endmodule

bind mem_arbiter mem_arbiter_checker arb_check_i (
    .clock      (clock),
    .reset      (reset),
    .wvalid_q   (wvalid_q),
    .exu_ready  (exu_ready),
    .lsu_rvalid (lsu_rvalid),
    .lsu_rready (lsu_rready),
    .lsu_wvalid (lsu_wvalid),
    .rvalid_q   (rvalid_q),
    .reg_valid  (reg_valid)
);

// File: testbench/mem_access_tb.sv
`timescale 1ns/10ps
`include "mem_access_defines.svh"

module mem_access_tb;
    import mem_access_pkg::*;

    localparam logic [1:0] op_store = 2'd0;
    localparam logic [1:0] op_load  = 2'd1;
    localparam logic [1:0] op_alu   = 2'd2;
    localparam logic [1:0] op_fetch = 2'd3;

    typedef struct packed {
        logic [1:0]   kind;
        word_t        addr;
        access_size_t size;
        logic         sign;
        word_t        data;
        word_t        exp_val;
        reg_addr_t    rd;
        burst_len_t   rlen;
        logic         burst;
        logic         contend;
        logic         gen;
        logic         sen;
        logic         err;
        logic         fence;
        csr_addr_t    csr;
        word_t        csr_data;
    } op_t;

    logic clock, reset;
    logic cah_valid, cah_burst, cah_ready;
    word_t cah_addr, cah_data;
    burst_len_t cah_rlen;
    logic exu_valid, exu_ready, exu_men, exu_gen, exu_sen, exu_write, exu_rsign;
    reg_addr_t exu_ard, reg_addr;
    word_t exu_rd, exu_csr, exu_wdata, exu_addr, reg_data, csr_data;
    csr_addr_t exu_acsr, csr_addr;
    access_size_t exu_mask;
    logic reg_valid, csr_valid, erri, erro, in_fencei, ot_fencei;
    err_type_t errtpi, errtpo;

    op_t   ops[$];
    word_t fetch_words[$];
    word_t model [0:`MEM_SRAM_DEPTH-1];
    int    cycle_count = 0;
    int    cycle_limit = 0;

    mem_access_top dut_i (.*);

    always #20 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $fatal(1, "timeout");
        end
    end

    // ------------------------------
    // compare tasks
    // ------------------------------

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_word(input word_t got, input word_t exp_val, input string what);
        if (got !== exp_val) begin
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp_val);
            abort_run();
        end
    endtask

    task automatic check_reg_addr(input reg_addr_t got, input reg_addr_t exp_val);
        if (got !== exp_val) begin
            $display("FAIL %0t: reg_addr is %0d, expected %0d", $time, got, exp_val);
            abort_run();
        end
    endtask

    task automatic check_csr_addr(input csr_addr_t got, input csr_addr_t exp_val);
        if (got !== exp_val) begin
            $display("FAIL %0t: csr_addr is %h, expected %h", $time, got, exp_val);
            abort_run();
        end
    endtask

    task automatic check_err(input err_type_t got, input err_type_t exp_val);
        if (got !== exp_val) begin
            $display("FAIL %0t: errtpo is %h, expected %h", $time, got, exp_val);
            abort_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp_val, input string what);
        if (got !== exp_val) begin
            $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp_val);
            abort_run();
        end
    endtask

    // ------------------------------
    // reference model
    // ------------------------------

    function automatic int word_index(input word_t addr);
        return int'(addr[`MEM_SRAM_AW+1:2]);
    endfunction

    function automatic void write_model(input word_t addr, input access_size_t size,
                                        input word_t data);
        int idx;
        idx = word_index(addr);
        case (size)
            2'd0: model[idx][addr[1:0]*8 +: 8] = data[7:0];
            2'd1: model[idx][addr[1]*16 +: 16] = data[15:0];
            default: model[idx] = data;
        endcase
    endfunction

    // lane picked by the low address bits, then sign or zero extended
    function automatic word_t load_view(input word_t w, input word_t addr,
                                        input access_size_t size, input logic sign);
        logic [7:0]  b;
        logic [15:0] h;
        b = w[addr[1:0]*8 +: 8];
        h = w[addr[1]*16 +: 16];
        case (size)
            2'd0: return sign ? {{24{b[7]}}, b} : {24'h0, b};
            2'd1: return sign ? {{16{h[15]}}, h} : {16'h0, h};
            default: return w;
        endcase
    endfunction

    // ------------------------------
    // operation table
    // ------------------------------

    function automatic op_t make_op(input logic [1:0] kind, input word_t addr);
        op_t op;
        op = '0;
        op.kind = kind;
        op.addr = addr;
        op.rd = reg_addr_t'($urandom_range(31, 1));
        return op;
    endfunction

    function automatic void add_store(input word_t addr, input access_size_t size);
        op_t op;
        op = make_op(op_store, addr);
        op.size = size;
        op.data = $urandom;
        write_model(addr, size, op.data);
        ops.push_back(op);
    endfunction

    function automatic void add_load(input word_t addr, input access_size_t size,
                                     input logic sign);
        op_t op;
        op = make_op(op_load, addr);
        op.size = size;
        op.sign = sign;
        op.gen = 1'b1;
        op.exp_val = load_view(model[word_index(addr)], addr, size, sign);
        ops.push_back(op);
    endfunction

    function automatic void add_alu(input logic gen, input logic sen, input logic err,
                                    input logic fence);
        op_t op;
        op = make_op(op_alu, '0);
        op.data = $urandom;
        op.gen = gen;
        op.sen = sen;
        op.err = err;
        op.fence = fence;
        op.csr = csr_addr_t'($urandom_range(4095, 0));
        op.csr_data = $urandom;
        ops.push_back(op);
    endfunction

    // contend adds a register op and a word load at addr during the fetch
    function automatic void add_fetch(input word_t addr, input burst_len_t rlen,
                                      input logic burst, input logic contend);
        op_t op;
        int  beats;
        op = make_op(op_fetch, addr);
        op.rlen = rlen;
        op.burst = burst;
        op.contend = contend;
        op.exp_val = model[word_index(addr)];
        beats = burst ? int'(rlen) + 1 : 1;
        for (int k = 0; k < beats; k++) begin
            fetch_words.push_back(model[word_index(addr + 4 * k)]);
        end
        ops.push_back(op);
    endfunction

    function automatic void build_table();
        for (int i = 0; i < 8; i++) add_store(4 * i, 2'd2);
        for (int i = 0; i < 8; i++) add_load(4 * i, 2'd2, 1'b0);
        for (int off = 0; off < 4; off++) begin
            add_store(32'h20 + off, 2'd0);
            add_load(32'h20 + off, 2'd0, 1'b0);
            add_load(32'h20 + off, 2'd0, 1'b1);
        end
        for (int off = 0; off < 4; off += 2) begin
            add_store(32'h24 + off, 2'd1);
            add_load(32'h24 + off, 2'd1, 1'b0);
            add_load(32'h24 + off, 2'd1, 1'b1);
        end
        // sub-word views of full words
        for (int i = 0; i < 4; i++) begin
            add_load(4 * i + i, 2'd0, 1'b1);
            add_load(4 * i + (i % 2) * 2, 2'd1, 1'b1);
        end
        add_alu(1'b1, 1'b0, 1'b0, 1'b0);
        add_alu(1'b0, 1'b1, 1'b0, 1'b0);
        add_alu(1'b1, 1'b1, 1'b1, 1'b0);
        add_alu(1'b0, 1'b0, 1'b0, 1'b1);
        add_alu(1'b1, 1'b0, 1'b1, 1'b1);
        add_fetch(32'h00, 8'd7, 1'b1, 1'b0);
        add_fetch(32'h20, 8'd1, 1'b1, 1'b1);
        add_fetch(32'h10, 8'd0, 1'b0, 1'b1);
    endfunction

    // ------------------------------
    // drivers
    // ------------------------------

    task automatic drive_exu(input op_t op);
        exu_valid = 1'b1;
        exu_men   = (op.kind == op_load) || (op.kind == op_store);
        exu_write = (op.kind == op_store);
        exu_addr  = op.addr;
        exu_mask  = op.size;
        exu_rsign = op.sign;
        exu_wdata = op.data;
        exu_ard   = op.rd;
        exu_rd    = op.data;
        exu_gen   = op.gen;
        exu_sen   = op.sen;
        exu_acsr  = op.csr;
        exu_csr   = op.csr_data;
        erri      = op.err;
        in_fencei = op.fence;
        errtpi    = err_type_t'($urandom_range(15, 0));
    endtask

    task automatic check_side_idle();
        check_flag(erro, 1'b0, "erro outside a handshake");
        check_flag(ot_fencei, 1'b0, "ot_fencei outside a handshake");
    endtask

    task automatic await_handshake(input op_t op);
        @(negedge clock);
        while (exu_ready !== 1'b1) begin
            check_side_idle();
            @(negedge clock);
        end
        check_flag(erro, op.err, "erro");
        check_flag(ot_fencei, op.fence, "ot_fencei");
        check_err(errtpo, errtpi);
        check_flag(reg_valid, (op.kind == op_alu) && op.gen, "reg_valid at handshake");
        check_flag(csr_valid, (op.kind == op_alu) && op.sen, "csr_valid at handshake");
        if (op.kind == op_alu && op.gen) begin
            check_reg_addr(reg_addr, op.rd);
            check_word(reg_data, op.data, "reg_data");
        end
        if (op.kind == op_alu && op.sen) begin
            check_csr_addr(csr_addr, op.csr);
            check_word(csr_data, op.csr_data, "csr_data");
        end
        @(posedge clock);
        #2;
        exu_valid = 1'b0;
        erri = 1'b0;
        in_fencei = 1'b0;
        // load data is written back on the third cycle
        if (op.kind == op_load) begin
            repeat (2) begin
                @(negedge clock);
                check_flag(reg_valid, 1'b0, "reg_valid before load data");
            end
            @(negedge clock);
            check_flag(reg_valid, 1'b1, "reg_valid for load");
            check_reg_addr(reg_addr, op.rd);
            check_word(reg_data, op.exp_val, "load data");
        end
    endtask

    task automatic run_fetch(input op_t op);
        op_t   alu;
        op_t   ld;
        word_t want;
        int    beats;
        int    beat;
        beats = op.burst ? int'(op.rlen) + 1 : 1;
        beat = 0;
        @(posedge clock);
        #2;
        cah_valid = 1'b1;
        cah_addr  = op.addr;
        cah_burst = op.burst;
        cah_rlen  = op.rlen;
        if (op.contend) begin
            alu = make_op(op_alu, '0);
            alu.gen = 1'b1;
            alu.data = $urandom;
            drive_exu(alu);
            await_handshake(alu);
            ld = make_op(op_load, op.addr);
            ld.size = 2'd2;
            ld.gen = 1'b1;
            ld.rd = op.rd;
            ld.exp_val = op.exp_val;
            // side channels stay raised while the load is held off
            ld.err = 1'b1;
            ld.fence = 1'b1;
            drive_exu(ld);
        end
        while (beat < beats) begin
            @(negedge clock);
            check_side_idle();
            if (op.contend) begin
                check_flag(exu_ready, 1'b0, "exu_ready during fetch");
            end
            if (cah_ready === 1'b1) begin
                want = fetch_words.pop_front();
                check_word(cah_data, want, "fetch beat");
                beat++;
            end
            @(posedge clock);
            #2;
        end
        cah_valid = 1'b0;
        if (op.contend) begin
            await_handshake(ld);
        end
    endtask

    // ------------------------------
    // main sequence
    // ------------------------------

    initial begin
        void'($urandom(32'ha26cac96));
        clock = 1'b0;
        reset = 1'b1;
        cah_valid = 1'b0;
        cah_addr = '0;
        cah_burst = 1'b0;
        cah_rlen = '0;
        exu_valid = 1'b0;
        exu_men = 1'b0;
        exu_ard = '0;
        exu_rd = '0;
        exu_gen = 1'b0;
        exu_acsr = '0;
        exu_csr = '0;
        exu_sen = 1'b0;
        exu_write = 1'b0;
        exu_wdata = '0;
        exu_addr = '0;
        exu_mask = '0;
        exu_rsign = 1'b0;
        erri = 1'b0;
        errtpi = '0;
        in_fencei = 1'b0;
        build_table();
        cycle_limit = ops.size() * 40;
        repeat (4) @(posedge clock);
        #2;
        reset = 1'b0;
        @(negedge clock);
        check_flag(reg_valid, 1'b0, "reg_valid after reset");
        check_flag(csr_valid, 1'b0, "csr_valid after reset");
        check_flag(cah_ready, 1'b0, "cah_ready after reset");
        check_side_idle();
        for (int i = 0; i < ops.size(); i++) begin
            if (ops[i].kind == op_fetch) begin
                run_fetch(ops[i]);
            end else begin
                @(posedge clock);
                #2;
                drive_exu(ops[i]);
                await_handshake(ops[i]);
            end
        end
        if (fetch_words.size() == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("%0d expected fetch words were never returned", fetch_words.size());
            $display("STATUS: FAIL");
            $fatal(1, "fetch beats missing");
        end
    end

endmodule

// File: mem_access.f
+incdir+design
design/mem_access_pkg.sv
design/mem_arbiter.sv
design/load_store_unit.sv
design/data_sram.sv
design/mem_access_top.sv
testbench/mem_arbiter_checker.sv
testbench/mem_access_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module mem_access_tb -f mem_access.f -o mem_access_sim; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/mem_access_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
